// File: src/voxel_raycaster_pkg.sv
// ----------------------------------------------------------
// Voxel ray caster shared definitions
// Widths, voxel and pixel structs, march states, shading constants
// ----------------------------------------------------------

package voxel_raycaster_pkg;

    // ----------------------------------------------------------
    // Geometry and march limits
    // ----------------------------------------------------------
    localparam int GRID_SIZE       = 64;
    localparam int FRAC_BITS       = 8;
    localparam int MAX_STEPS       = 128;
    localparam int ALPHA_THRESHOLD = 10;

    typedef logic [5:0]         voxel_coord_t;
    typedef logic [17:0]        voxel_addr_t;
    typedef logic [63:0]        voxel_word_t;
    typedef logic [7:0]         channel_t;
    typedef logic [3:0]         material_type_t;
    typedef logic [7:0]         step_count_t;
    typedef logic signed [23:0] ray_pos_t;
    typedef logic [10:0]        pixel_idx_t;
    typedef logic [31:0]        pixel_addr_t;

    // Same bit order as a voxel address {x, y, z}
    typedef struct packed {
        voxel_coord_t x;
        voxel_coord_t y;
        voxel_coord_t z;
    } voxel_pos_t;

    // Voxel word bits 63:4, the low nibble carries nothing
    typedef struct packed {
        channel_t       props;
        channel_t       emissive;
        channel_t       alpha;
        channel_t       light;
        channel_t       red;
        channel_t       green;
        channel_t       blue;
        material_type_t mat_type;
    } voxel_fields_t;

    // Upper half is the old word0, lower half the old word1
    typedef struct packed {
        channel_t reflection;
        channel_t refraction;
        channel_t attenuation;
        channel_t emission;
        channel_t red;
        channel_t green;
        channel_t blue;
        channel_t material_id;
    } pixel_out_t;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        STEP,
        FETCH,
        SHADE,
        WRITE,
        NEXT
    } march_state_e;

    // ----------------------------------------------------------
    // Shading constants
    // ----------------------------------------------------------
    localparam material_type_t MAT_EMISSIVE = 4'd1;
    localparam material_type_t MAT_GLASSY   = 4'd2;
    localparam material_type_t MAT_MIRROR   = 4'd3;
    localparam material_type_t MAT_CRYSTAL  = 4'd5;

    localparam channel_t SEL_BOOST_R = 8'd96;
    localparam channel_t SEL_BOOST_G = 8'd16;
    localparam channel_t SEL_BOOST_B = 8'd96;

    localparam pixel_out_t SKY_PIXEL = '{
        reflection:  8'd0,
        refraction:  8'd0,
        attenuation: 8'd255,
        emission:    8'd0,
        red:         8'd30,
        green:       8'd30,
        blue:        8'd60,
        material_id: 8'hFF
    };

endpackage

// File: src/ray_march_fsm.sv
// ----------------------------------------------------------
// Ray march control FSM
// Sequences frame start, per-pixel setup, sampling, shading and
// the framebuffer write, and brackets the frame with busy/done
// ----------------------------------------------------------

`timescale 1ns/1ps

module ray_march_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic last_x,
    input  logic last_y,
    input  logic limit_reached,
    input  logic hit,
    output logic busy,
    output logic done,
    output logic scan_clear,
    output logic scan_advance,
    output logic ray_setup,
    output logic ray_step,
    output logic sample_clear,
    output logic sample_en,
    output logic shade_en,
    output logic pixel_write_en
);
    import voxel_raycaster_pkg::*;

    march_state_e state;
    march_state_e state_next;
    logic         ray_end;
    logic         frame_end;

    // Ray ends on the first hit or once all samples are spent
    assign ray_end   = hit || limit_reached;
    assign frame_end = last_x && last_y;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    state_next = start ? SETUP : IDLE;
            SETUP:   state_next = STEP;
            STEP:    state_next = ray_end ? SHADE : FETCH;
            FETCH:   state_next = STEP;
            SHADE:   state_next = WRITE;
            WRITE:   state_next = NEXT;
            NEXT:    state_next = frame_end ? IDLE : SETUP;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            state <= state_next;
            done  <= (state == NEXT) && frame_end;
            if (state == IDLE && start) begin
                busy <= 1'b1;
            end else if (state == NEXT && frame_end) begin
                busy <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------
    // Strobes decoded from the current state
    // ----------------------------------------------------------
    assign scan_clear     = (state == IDLE) && start;
    assign ray_setup      = (state == SETUP);
    assign sample_clear   = (state == SETUP);
    assign ray_step       = (state == STEP) && !ray_end;
    assign sample_en      = (state == FETCH);
    assign shade_en       = (state == SHADE);
    assign pixel_write_en = (state == WRITE);
    assign scan_advance   = (state == NEXT);

endmodule

// File: src/pixel_scan_counter.sv
// ----------------------------------------------------------
// Raster pixel counter
// Walks x then y over the screen and forms the linear address
// ----------------------------------------------------------

`timescale 1ns/1ps

module pixel_scan_counter #(
    parameter int SCREEN_WIDTH  = 320,
    parameter int SCREEN_HEIGHT = 240
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             clear,
    input  logic                             advance,
    output voxel_raycaster_pkg::pixel_idx_t  pixel_x,
    output voxel_raycaster_pkg::pixel_idx_t  pixel_y,
    output logic                             last_x,
    output logic                             last_y,
    output voxel_raycaster_pkg::pixel_addr_t pixel_addr
);
    import voxel_raycaster_pkg::*;

    assign last_x = (pixel_x == pixel_idx_t'(SCREEN_WIDTH - 1));
    assign last_y = (pixel_y == pixel_idx_t'(SCREEN_HEIGHT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_x <= '0;
            pixel_y <= '0;
        end else if (clear) begin
            pixel_x <= '0;
            pixel_y <= '0;
        end else if (advance) begin
            if (last_x) begin
                pixel_x <= '0;
                // Wraps to the top line after the last pixel
                pixel_y <= last_y ? '0 : pixel_y + 1'b1;
            end else begin
                pixel_x <= pixel_x + 1'b1;
            end
        end
    end

    // Row-major framebuffer address
    assign pixel_addr = pixel_addr_t'(pixel_y) * pixel_addr_t'(SCREEN_WIDTH)
                      + pixel_addr_t'(pixel_x);

endmodule

// File: src/ray_stepper.sv
// ----------------------------------------------------------
// Orthographic ray stepper
// Maps a pixel onto the grid, marches along -x by half a voxel
// per sample and issues the voxel memory reads
// ----------------------------------------------------------

`timescale 1ns/1ps

module ray_stepper #(
    parameter int SCREEN_WIDTH  = 320,
    parameter int SCREEN_HEIGHT = 240
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             setup,
    input  logic                             step,
    input  voxel_raycaster_pkg::pixel_idx_t  pixel_x,
    input  voxel_raycaster_pkg::pixel_idx_t  pixel_y,
    output voxel_raycaster_pkg::voxel_pos_t  sample_pos,
    output voxel_raycaster_pkg::voxel_addr_t voxel_addr,
    output logic                             voxel_read_en,
    output voxel_raycaster_pkg::step_count_t step_count,
    output logic                             limit_reached
);
    import voxel_raycaster_pkg::*;

    localparam ray_pos_t HALF_VOXEL = ray_pos_t'(1 << (FRAC_BITS - 1));

    ray_pos_t     pos_x;
    ray_pos_t     pos_y;
    ray_pos_t     pos_z;
    ray_pos_t     grid_x;
    ray_pos_t     grid_y;
    ray_pos_t     grid_z;
    voxel_coord_t map_y;
    voxel_coord_t map_z;
    voxel_pos_t   cur_pos;

    // Screen to grid scaling, y from the row and z from the column
    assign map_y = voxel_coord_t'((32'(pixel_y) * (GRID_SIZE - 1)) / (SCREEN_HEIGHT - 1));
    assign map_z = voxel_coord_t'((32'(pixel_x) * (GRID_SIZE - 1)) / (SCREEN_WIDTH - 1));

    // Offset on y/z stays under one voxel
    assign grid_x = pos_x >>> FRAC_BITS;
    assign grid_y = (pos_y + ray_pos_t'(step_count)) >>> FRAC_BITS;
    assign grid_z = (pos_z + ray_pos_t'(step_count)) >>> FRAC_BITS;

    // Truncation wraps x = -1 back to 63
    assign cur_pos = '{x: grid_x[5:0], y: grid_y[5:0], z: grid_z[5:0]};

    assign limit_reached = (step_count >= step_count_t'(MAX_STEPS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_count    <= '0;
            voxel_read_en <= 1'b0;
        end else begin
            voxel_read_en <= step;
            if (setup) begin
                step_count <= '0;
            end else if (step) begin
                step_count <= step_count + 1'b1;
            end
        end
    end

    // Ray position and read address
    always_ff @(posedge clk) begin
        if (setup) begin
            pos_x <= ray_pos_t'(GRID_SIZE - 1) <<< FRAC_BITS;
            pos_y <= ray_pos_t'(map_y) <<< FRAC_BITS;
            pos_z <= ray_pos_t'(map_z) <<< FRAC_BITS;
        end else if (step) begin
            pos_x      <= pos_x - HALF_VOXEL;
            sample_pos <= cur_pos;
            voxel_addr <= voxel_addr_t'(cur_pos);
        end
    end

endmodule

// File: src/voxel_sampler.sv
// ----------------------------------------------------------
// Voxel occupancy sampler
// Tests returned voxel words and keeps the first hit of a ray
// ----------------------------------------------------------

`timescale 1ns/1ps

module voxel_sampler (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               clear,
    input  logic                               sample_en,
    input  voxel_raycaster_pkg::voxel_word_t   voxel_data,
    input  voxel_raycaster_pkg::voxel_pos_t    sample_pos,
    output logic                               hit,
    output voxel_raycaster_pkg::voxel_fields_t fields,
    output voxel_raycaster_pkg::voxel_pos_t    hit_pos
);
    import voxel_raycaster_pkg::*;

    voxel_fields_t word_fields;
    logic          occupied;
    logic          first_hit;

    assign word_fields = voxel_fields_t'(voxel_data[63:4]);

    // Empty words and near-transparent voxels are passed through
    assign occupied  = (voxel_data != '0)
                    && (word_fields.alpha > channel_t'(ALPHA_THRESHOLD));
    assign first_hit = sample_en && !hit && occupied;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit <= 1'b0;
        end else if (clear) begin
            hit <= 1'b0;
        end else if (first_hit) begin
            hit <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (first_hit) begin
            fields  <= word_fields;
            hit_pos <= sample_pos;
        end
    end

endmodule

// File: src/pixel_shader.sv
// ----------------------------------------------------------
// Pixel shader
// Lights the hit voxel, adds emission, material terms and the
// selection highlight, or substitutes the sky pixel on a miss
// ----------------------------------------------------------

`timescale 1ns/1ps

module pixel_shader (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               shade_en,
    input  logic                               hit,
    input  voxel_raycaster_pkg::voxel_fields_t fields,
    input  voxel_raycaster_pkg::voxel_pos_t    hit_pos,
    input  voxel_raycaster_pkg::step_count_t   step_count,
    input  logic                               sel_active,
    input  voxel_raycaster_pkg::voxel_pos_t    sel_pos,
    output voxel_raycaster_pkg::pixel_out_t    pixel
);
    import voxel_raycaster_pkg::*;

    channel_t   lit_r;
    channel_t   lit_g;
    channel_t   lit_b;
    channel_t   base_r;
    channel_t   base_g;
    channel_t   base_b;
    logic       selected;
    pixel_out_t shaded;

    // colour * light / 256
    function automatic channel_t light_scale(channel_t colour, channel_t light);
        logic [15:0] prod;
        begin
            prod = colour * light;
            return prod[15:8];
        end
    endfunction

    function automatic channel_t sat_add(channel_t a, channel_t b);
        logic [8:0] sum;
        begin
            sum = {1'b0, a} + {1'b0, b};
            return sum[8] ? 8'hFF : sum[7:0];
        end
    endfunction

    assign lit_r = light_scale(fields.red, fields.light);
    assign lit_g = light_scale(fields.green, fields.light);
    assign lit_b = light_scale(fields.blue, fields.light);

    assign selected = sel_active && (hit_pos == sel_pos);

    // ----------------------------------------------------------
    // Shading of a hit
    // ----------------------------------------------------------
    always_comb begin
        // Black after lighting falls back to the raw colour
        if (lit_r == '0 && lit_g == '0 && lit_b == '0) begin
            base_r = fields.red;
            base_g = fields.green;
            base_b = fields.blue;
        end else begin
            base_r = lit_r;
            base_g = lit_g;
            base_b = lit_b;
        end

        shaded.red         = sat_add(base_r, fields.emissive);
        shaded.green       = sat_add(base_g, fields.emissive);
        shaded.blue        = sat_add(base_b, fields.emissive);
        shaded.material_id = {fields.mat_type, 4'h0};
        shaded.attenuation = step_count;

        case (fields.mat_type)
            MAT_MIRROR:  shaded.reflection = 8'd255;
            MAT_CRYSTAL: shaded.reflection = 8'd200;
            default:     shaded.reflection = {fields.props[7:5], 5'd0};
        endcase

        case (fields.mat_type)
            MAT_CRYSTAL: shaded.refraction = 8'd128;
            MAT_GLASSY:  shaded.refraction = 8'd85;
            default:     shaded.refraction = 8'd0;
        endcase

        shaded.emission = (fields.mat_type == MAT_EMISSIVE) ? fields.emissive : 8'd0;

        if (selected) begin
            shaded.red   = sat_add(shaded.red, SEL_BOOST_R);
            shaded.green = sat_add(shaded.green, SEL_BOOST_G);
            shaded.blue  = sat_add(shaded.blue, SEL_BOOST_B);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel <= SKY_PIXEL;
        end else if (shade_en) begin
            pixel <= hit ? shaded : SKY_PIXEL;
        end
    end

endmodule

// File: src/voxel_raycaster.sv
// ----------------------------------------------------------
// Voxel ray caster top level
// One orthographic ray per pixel through a 64^3 volume, one
// 64-bit pixel written per framebuffer address
// ----------------------------------------------------------

`timescale 1ns/1ps

module voxel_raycaster #(
    parameter int SCREEN_WIDTH  = 320,
    parameter int SCREEN_HEIGHT = 240
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic                             sel_active,
    input  voxel_raycaster_pkg::voxel_pos_t  sel_pos,
    output voxel_raycaster_pkg::voxel_addr_t voxel_addr,
    output logic                             voxel_read_en,
    input  voxel_raycaster_pkg::voxel_word_t voxel_data,
    output voxel_raycaster_pkg::pixel_out_t  pixel,
    output voxel_raycaster_pkg::pixel_addr_t pixel_addr,
    output logic                             pixel_write_en,
    output logic                             busy,
    output logic                             done
);
    import voxel_raycaster_pkg::*;

    // Control strobes
    logic scan_clear;
    logic scan_advance;
    logic ray_setup;
    logic ray_step;
    logic sample_clear;
    logic sample_en;
    logic shade_en;
    logic last_x;
    logic last_y;
    logic limit_reached;
    logic hit;

    // Datapath
    pixel_idx_t    pixel_x;
    pixel_idx_t    pixel_y;
    voxel_pos_t    sample_pos;
    voxel_pos_t    hit_pos;
    voxel_fields_t fields;
    step_count_t   step_count;

    ray_march_fsm fsm0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .last_x         (last_x),
        .last_y         (last_y),
        .limit_reached  (limit_reached),
        .hit            (hit),
        .busy           (busy),
        .done           (done),
        .scan_clear     (scan_clear),
        .scan_advance   (scan_advance),
        .ray_setup      (ray_setup),
        .ray_step       (ray_step),
        .sample_clear   (sample_clear),
        .sample_en      (sample_en),
        .shade_en       (shade_en),
        .pixel_write_en (pixel_write_en)
    );

    pixel_scan_counter #(
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT)
    ) scan0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (scan_clear),
        .advance    (scan_advance),
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y),
        .last_x     (last_x),
        .last_y     (last_y),
        .pixel_addr (pixel_addr)
    );

    ray_stepper #(
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT)
    ) stepper0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .setup         (ray_setup),
        .step          (ray_step),
        .pixel_x       (pixel_x),
        .pixel_y       (pixel_y),
        .sample_pos    (sample_pos),
        .voxel_addr    (voxel_addr),
        .voxel_read_en (voxel_read_en),
        .step_count    (step_count),
        .limit_reached (limit_reached)
    );

    voxel_sampler sampler0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (sample_clear),
        .sample_en  (sample_en),
        .voxel_data (voxel_data),
        .sample_pos (sample_pos),
        .hit        (hit),
        .fields     (fields),
        .hit_pos    (hit_pos)
    );

    pixel_shader shader0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .shade_en   (shade_en),
        .hit        (hit),
        .fields     (fields),
        .hit_pos    (hit_pos),
        .step_count (step_count),
        .sel_active (sel_active),
        .sel_pos    (sel_pos),
        .pixel      (pixel)
    );

endmodule

// File: dv/tb_voxel_raycaster.sv
// ----------------------------------------------------------
// Voxel ray caster testbench
// Table-driven scenes in a voxel memory model, each frame
// checked against a reference ray march and shading model
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_voxel_raycaster;
    import voxel_raycaster_pkg::*;

    localparam int SCREEN_W   = 8;
    localparam int SCREEN_H   = 6;
    localparam int NUM_PIXELS = SCREEN_W * SCREEN_H;
    localparam int NUM_ROWS   = 10;
    localparam int LAYER_X    = 60;
    localparam longint WATCHDOG_NS = longint'(NUM_ROWS) * NUM_PIXELS * 260 * 4 + 400;

    typedef enum logic [1:0] {
        SCENE_EMPTY,
        SCENE_WALL,
        SCENE_LAYER,
        SCENE_SWEEP
    } scene_kind_e;

    typedef struct packed {
        scene_kind_e    kind;
        voxel_coord_t   depth;
        material_type_t mat;
        channel_t       alpha;
        channel_t       light;
        channel_t       emissive;
        logic           sel_active;
        voxel_pos_t     sel_pos;
    } test_row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    logic        sel_active;
    voxel_pos_t  sel_pos;
    voxel_addr_t voxel_addr;
    logic        voxel_read_en;
    voxel_word_t voxel_data;
    pixel_out_t  pixel;
    pixel_addr_t pixel_addr;
    logic        pixel_write_en;
    logic        busy;
    logic        done;

    test_row_t   rows [NUM_ROWS];
    test_row_t   cur_row;
    channel_t    scene_r;
    channel_t    scene_g;
    channel_t    scene_b;
    channel_t    scene_props;
    logic [31:0] rng_state = 32'h911c;
    int          cur_idx;

    always #2 clk = ~clk;

    voxel_raycaster #(
        .SCREEN_WIDTH  (SCREEN_W),
        .SCREEN_HEIGHT (SCREEN_H)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .sel_active     (sel_active),
        .sel_pos        (sel_pos),
        .voxel_addr     (voxel_addr),
        .voxel_read_en  (voxel_read_en),
        .voxel_data     (voxel_data),
        .pixel          (pixel),
        .pixel_addr     (pixel_addr),
        .pixel_write_en (pixel_write_en),
        .busy           (busy),
        .done           (done)
    );

    // ----------------------------------------------------------
    // Scene generation and voxel memory model
    // ----------------------------------------------------------
    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Word layout from the top is props, emissive, alpha, light, r, g, b, type and a spare nibble
    function automatic voxel_word_t make_word(channel_t props, channel_t emis, channel_t alpha,
                                              channel_t light, channel_t r, channel_t g,
                                              channel_t b, material_type_t mat);
        return {props, emis, alpha, light, r, g, b, mat, 4'h5};
    endfunction

    function automatic material_type_t sweep_mat(voxel_coord_t z);
        case (z % 5)
            0:       return 4'd1;
            1:       return 4'd2;
            2:       return 4'd3;
            3:       return 4'd5;
            default: return 4'd9;
        endcase
    endfunction

    function automatic voxel_word_t scene_word(voxel_addr_t addr, test_row_t row, channel_t cr,
                                               channel_t cg, channel_t cb, channel_t cp);
        voxel_coord_t   x;
        voxel_coord_t   y;
        voxel_coord_t   z;
        material_type_t mat;
        x = addr[17:12];
        y = addr[11:6];
        z = addr[5:0];
        mat = (row.kind == SCENE_SWEEP) ? sweep_mat(z) : row.mat;
        if (row.kind == SCENE_EMPTY) begin
            return '0;
        end
        // See-through sheet with alpha 10 on odd rows and 0 on even rows
        if (row.kind == SCENE_LAYER && x == voxel_coord_t'(LAYER_X)) begin
            return make_word(cp, 8'd0, y[0] ? 8'd10 : 8'd0, 8'd255,
                             8'd200, 8'd200, 8'd200, 4'd7);
        end
        if (x == row.depth) begin
            return make_word(cp, row.emissive, row.alpha, row.light, cr ^ {2'b0, y},
                             cg ^ {2'b0, z}, cb ^ {2'b0, x}, mat);
        end
        return '0;
    endfunction

    assign voxel_data = scene_word(voxel_addr, cur_row, scene_r, scene_g, scene_b, scene_props);

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic channel_t clamp_channel(int v);
        return (v > 255) ? 8'd255 : channel_t'(v);
    endfunction

    function automatic pixel_out_t shade_hit(voxel_word_t w, int n, voxel_pos_t pos);
        pixel_out_t     p;
        int             lr;
        int             lg;
        int             lb;
        int             light;
        int             emis;
        material_type_t mat;
        light = int'(w[39:32]);
        emis  = int'(w[55:48]);
        mat   = w[7:4];
        lr = int'(w[31:24]) * light / 256;
        lg = int'(w[23:16]) * light / 256;
        lb = int'(w[15:8]) * light / 256;
        if (lr == 0 && lg == 0 && lb == 0) begin
            lr = int'(w[31:24]);
            lg = int'(w[23:16]);
            lb = int'(w[15:8]);
        end
        p.red         = clamp_channel(lr + emis);
        p.green       = clamp_channel(lg + emis);
        p.blue        = clamp_channel(lb + emis);
        p.material_id = {mat, 4'h0};
        p.attenuation = channel_t'(n);
        p.reflection  = (mat == 4'd3) ? 8'd255 : (mat == 4'd5) ? 8'd200 : (w[63:56] & 8'hE0);
        p.refraction  = (mat == 4'd5) ? 8'd128 : (mat == 4'd2) ? 8'd85 : 8'd0;
        p.emission    = (mat == 4'd1) ? channel_t'(emis) : 8'd0;
        if (cur_row.sel_active && pos == cur_row.sel_pos) begin
            p.red   = clamp_channel(int'(p.red) + 96);
            p.green = clamp_channel(int'(p.green) + 16);
            p.blue  = clamp_channel(int'(p.blue) + 96);
        end
        return p;
    endfunction

    // March along -x by half a voxel with y and z fixed by the pixel
    function automatic pixel_out_t expected_pixel(input int px, input int py, output int samples);
        voxel_coord_t gx;
        voxel_coord_t gy;
        voxel_coord_t gz;
        voxel_word_t  w;
        gy = voxel_coord_t'((py * (GRID_SIZE - 1)) / (SCREEN_H - 1));
        gz = voxel_coord_t'((px * (GRID_SIZE - 1)) / (SCREEN_W - 1));
        for (int k = 0; k < MAX_STEPS; k++) begin
            gx = voxel_coord_t'(63 - (k + 1) / 2);
            w  = scene_word({gx, gy, gz}, cur_row, scene_r, scene_g, scene_b, scene_props);
            if (w != '0 && int'(w[47:40]) > ALPHA_THRESHOLD) begin
                samples = k + 1;
                return shade_hit(w, k + 1, '{x: gx, y: gy, z: gz});
            end
        end
        samples = MAX_STEPS;
        return SKY_PIXEL;
    endfunction

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_pixel(input string name, input pixel_out_t got, input pixel_out_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s (row %0d): got 0x%h expected 0x%h", name, cur_idx, got, exp);
            stop_with_failure("Pixel value mismatch");
        end
    endtask

    task automatic check_addr(input string name, input pixel_addr_t got, input pixel_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s (row %0d): got 0x%h expected 0x%h", name, cur_idx, got, exp);
            stop_with_failure("Pixel address mismatch");
        end
    endtask

    task automatic check_count(input string name, input step_count_t got, input step_count_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s (row %0d): got 0x%h expected 0x%h", name, cur_idx, got, exp);
            stop_with_failure("Sample count mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s (row %0d): got 0x%h expected 0x%h", name, cur_idx, got, exp);
            stop_with_failure("Control signal mismatch");
        end
    endtask

    // ----------------------------------------------------------
    // Test table and frame runner
    // ----------------------------------------------------------
    task automatic load_table();
        rows[0] = '{SCENE_EMPTY, 6'd0,  4'd0, 8'd0,   8'd0,   8'd0,   1'b0, '0};
        rows[1] = '{SCENE_WALL,  6'd63, 4'd0, 8'd200, 8'd128, 8'd0,   1'b0, '0};
        rows[2] = '{SCENE_WALL,  6'd40, 4'd1, 8'd11,  8'd255, 8'd200, 1'b0, '0};
        rows[3] = '{SCENE_WALL,  6'd20, 4'd4, 8'd255, 8'd0,   8'd10,  1'b0, '0};
        rows[4] = '{SCENE_WALL,  6'd0,  4'd3, 8'd64,  8'd1,   8'd0,   1'b0, '0};
        rows[5] = '{SCENE_LAYER, 6'd30, 4'd2, 8'd100, 8'd200, 8'd50,  1'b0, '0};
        rows[6] = '{SCENE_SWEEP, 6'd50, 4'd0, 8'd80,  8'd160, 8'd5,   1'b0, '0};
        rows[7] = '{SCENE_WALL,  6'd33, 4'd6, 8'd90,  8'd180, 8'd40,  1'b1, '{6'd33, 6'd25, 6'd27}};
        rows[8] = '{SCENE_WALL,  6'd33, 4'd6, 8'd90,  8'd180, 8'd40,  1'b0, '{6'd33, 6'd25, 6'd27}};
        rows[9] = '{SCENE_EMPTY, 6'd0,  4'd0, 8'd0,   8'd0,   8'd0,   1'b0, '0};
    endtask

    task automatic run_frame(input int idx);
        int         pixels;
        int         reads;
        int         tail;
        int         exp_samples;
        pixel_out_t exp_pix;
        logic       frame_done;
        cur_idx     = idx;
        cur_row     = rows[idx];
        rng_state   = xorshift32(rng_state);
        scene_r     = rng_state[7:0];
        scene_g     = rng_state[15:8];
        scene_b     = rng_state[23:16];
        scene_props = rng_state[31:24];
        sel_active  = cur_row.sel_active;
        sel_pos     = cur_row.sel_pos;
        start       = 1'b1;
        pixels      = 0;
        reads       = 0;
        tail        = 0;
        frame_done  = 1'b0;
        while (!frame_done) begin
            @(negedge clk);
            start = 1'b0;
            if (pixels == NUM_PIXELS) begin
                // NEXT of the last pixel, then the cycle that carries done
                tail++;
                check_bit("voxel_read_en", voxel_read_en, 1'b0);
                check_bit("pixel_write_en", pixel_write_en, 1'b0);
                check_bit("done", done, tail == 2);
                check_bit("busy", busy, tail != 2);
                frame_done = (tail == 2);
            end else begin
                check_bit("done", done, 1'b0);
                check_bit("busy", busy, 1'b1);
                if (voxel_read_en) begin
                    reads++;
                end
                if (pixel_write_en) begin
                    exp_pix = expected_pixel(pixels % SCREEN_W, pixels / SCREEN_W, exp_samples);
                    check_addr("pixel_addr", pixel_addr, pixel_addr_t'(pixels));
                    check_pixel("pixel", pixel, exp_pix);
                    check_count("voxel_read_en count", step_count_t'(reads),
                                step_count_t'(exp_samples));
                    reads = 0;
                    pixels++;
                    // A start while busy must have no effect
                    if (pixels == 1) begin
                        start = 1'b1;
                    end
                end
            end
        end
        @(negedge clk);
        check_bit("done", done, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("pixel_write_en", pixel_write_en, 1'b0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("Watchdog expired before all frames finished");
    end

    initial begin
        rst_n       = 1'b0;
        start       = 1'b0;
        sel_active  = 1'b0;
        sel_pos     = '0;
        cur_idx     = 0;
        load_table();
        cur_row     = rows[0];
        scene_r     = '0;
        scene_g     = '0;
        scene_b     = '0;
        scene_props = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("pixel_write_en", pixel_write_en, 1'b0);
        check_bit("voxel_read_en", voxel_read_en, 1'b0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_frame(i);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: voxel_raycaster.f
src/voxel_raycaster_pkg.sv
src/ray_march_fsm.sv
src/pixel_scan_counter.sv
src/ray_stepper.sv
src/voxel_sampler.sv
src/pixel_shader.sv
src/voxel_raycaster.sv
dv/tb_voxel_raycaster.sv

// File: Bender.yml
package:
  name: voxel_raycaster

sources:
  - files:
      - src/voxel_raycaster_pkg.sv
      - src/ray_march_fsm.sv
      - src/pixel_scan_counter.sv
      - src/ray_stepper.sv
      - src/voxel_sampler.sv
      - src/pixel_shader.sv
      - src/voxel_raycaster.sv
  - target: simulation
    files:
      - dv/tb_voxel_raycaster.sv
